// ==== isaPkg.sv ====
package isaPkg;

  // Main opcode map, byte 0 of every instruction
  localparam logic [7:0] opAluLimit    = 8'd39;   // 0..39, bit 2 picks mul
  localparam logic [7:0] opShiftLo     = 8'd40;
  localparam logic [7:0] opShiftHi     = 8'd45;
  localparam logic [7:0] opCmpLo       = 8'd46;   // Compare and test
  localparam logic [7:0] opCmpHi       = 8'd53;
  localparam logic [7:0] opLdStLo      = 8'd64;   // Bit 0 set means store
  localparam logic [7:0] opLdStHi      = 8'd111;
  localparam logic [7:0] opCondJumpLo  = 8'd160;
  localparam logic [7:0] opCondJumpHi  = 8'd175;
  localparam logic [7:0] opLongJump    = 8'd180;
  localparam logic [7:0] opUncondJump  = 8'd181;
  localparam logic [7:0] opBranchGroup = 8'd182;  // Indirect, call, return
  localparam logic [7:0] opSys         = 8'hff;

  // Sub-operations of opBranchGroup
  localparam logic [2:0] subIndir = 3'd0;
  localparam logic [2:0] subCallA = 3'd1;
  localparam logic [2:0] subCallB = 3'd2;
  localparam logic [2:0] subRet   = 3'd3;

  typedef struct packed {
    logic indir;
    logic jump;
    logic alu;
    logic shift;
    logic mul;
    logic load;
    logic store;
    logic sys;
  } instrClassT;

  typedef struct packed {
    logic [23:0] operands;
    logic [7:0]  opcode;
  } instrBaseT;

  // Layout used by the branch group only
  typedef struct packed {
    logic [15:0] upper;
    logic [2:0]  subOp;
    logic [4:0]  lower;
    logic [7:0]  opcode;
  } instrBranchT;

  typedef union packed {
    instrBaseT   base;
    instrBranchT branch;
  } instrWordU;

endpackage

// ==== bundlePkg.sv ====
package bundlePkg;

  import isaPkg::*;

  localparam int numParcels    = 15;
  localparam int numSlots      = 8;
  localparam int numJumpSlots  = 4;
  localparam int parcelBits    = 16;
  localparam int windowParcels = 4;   // Longest instruction in parcels
  localparam int windowBits    = windowParcels * parcelBits;

  typedef logic [parcelBits-1:0] parcelT;
  typedef logic [3:0]            offsetT;
  typedef logic [4:0]            countT;

  typedef struct packed {
    parcelT [numParcels-1:0]  parcels;
    parcelT                   tailParcel;
    logic   [numParcels-1:0]  endBits;
    offsetT                   startOff;
  } fetchBundleT;

  typedef struct packed {
    logic [windowBits-1:0]    window;
    offsetT                   offset;
    logic [windowParcels-1:0] cont;
    instrClassT               cls;
  } instrSlotT;

  // Four parcels from parcel k, tail appended, zeros past the tail
  function automatic logic [windowBits-1:0] parcelWindow(fetchBundleT b, int k);
    logic [(numParcels + windowParcels) * parcelBits - 1:0] ext;
    ext = {{((windowParcels - 1) * parcelBits){1'b0}}, b.tailParcel, b.parcels};
    return ext[k * parcelBits +: windowBits];
  endfunction

  // Continuation bits of parcel k
  function automatic logic [windowParcels-1:0] parcelCont(
    logic [numParcels-1:0] endBits,
    int k
  );
    logic [numParcels + windowParcels - 2:0] ext;
    ext = {{(windowParcels - 1){1'b0}}, endBits};  // No end bits above 14
    return ~ext[k +: windowParcels];
  endfunction

  function automatic countT popCount(logic [numParcels-1:0] v);
    countT n;
    n = '0;
    for (int i = 0; i < numParcels; i++) begin
      n = n + countT'(v[i]);
    end
    return n;
  endfunction

endpackage

// ==== instrClassDecode.sv ====
module instrClassDecode
  import isaPkg::*;
(
  input  instrWordU  instr,
  input  logic [3:0] cont,
  output instrClassT cls
);

  logic [7:0] opcode;
  logic       twoParcels;
  logic       isAluMul;
  logic       isShift;
  logic       isCmp;
  logic       isLdSt;
  logic       isCondJump;
  logic       isDirectJump;
  logic       isBranch;

  assign opcode     = instr.base.opcode;
  assign twoParcels = cont[0];  // Instruction spans at least two parcels

  assign isAluMul     = opcode <= opAluLimit;
  assign isShift      = opcode inside {[opShiftLo:opShiftHi]};
  assign isCmp        = opcode inside {[opCmpLo:opCmpHi]};
  assign isLdSt       = opcode inside {[opLdStLo:opLdStHi]};
  assign isCondJump   = opcode inside {[opCondJumpLo:opCondJumpHi]};
  assign isDirectJump = (opcode == opLongJump) || (opcode == opUncondJump);
  assign isBranch     = opcode == opBranchGroup;

  always_comb begin
    cls = '0;
    if (twoParcels) begin
      if (isAluMul) begin
        cls.alu = ~opcode[2];
        cls.mul = opcode[2];
      end else if (isShift) begin
        cls.shift = 1'b1;
      end else if (isCmp) begin
        cls.alu = 1'b1;
      end else if (isLdSt) begin
        cls.load  = ~opcode[0];
        cls.store = opcode[0];
      end else if (isCondJump) begin
        cls.jump = 1'b1;
        cls.alu  = 1'b1;  // Condition evaluated in the ALU
      end else if (isDirectJump) begin
        cls.jump = 1'b1;
      end else if (isBranch) begin
        case (instr.branch.subOp)
          subIndir, subRet: begin
            cls.jump  = 1'b1;
            cls.indir = 1'b1;
          end
          subCallA, subCallB: begin
            cls.jump  = 1'b1;
            cls.store = 1'b1;  // Return address push
          end
          default: begin
            cls = '0;
          end
        endcase
      end
    end
    // System opcode is valid at any length
    if (opcode == opSys) begin
      cls.sys = 1'b1;
    end
  end

endmodule

// ==== parcelBoundary.sv ====
module parcelBoundary
  import isaPkg::*;
  import bundlePkg::*;
(
  input  logic [numParcels-1:0]       endBits,
  input  offsetT                      startOff,
  input  instrClassT [numParcels-1:0] parcelCls,
  output logic [numParcels-1:0]       startMask,
  output logic [numParcels-1:0]       jumpMask,
  output logic                        error,
  output logic                        jumpError
);

  logic [numParcels-1:0] prevEnd;
  countT                 startCount;
  countT                 jumpCount;

  // End vector shifted up by one, bit -1 always set
  assign prevEnd = {endBits[numParcels-2:0], 1'b1};

  always_comb begin
    for (int k = 0; k < numParcels; k++) begin
      startMask[k] = prevEnd[k] && (offsetT'(k) >= startOff);
      jumpMask[k]  = startMask[k] && parcelCls[k].jump;
    end
  end

  assign startCount = popCount(startMask);
  assign jumpCount  = popCount(jumpMask);

  // Offset 15 points at the tail, nothing can start there
  assign error     = (startCount > numSlots) || (startOff == offsetT'(numParcels));
  assign jumpError = jumpCount > numJumpSlots;

endmodule

// ==== slotCompactor.sv ====
module slotCompactor
  import isaPkg::*;
  import bundlePkg::*;
#(
  parameter int numOut = numSlots
) (
  input  logic [numParcels-1:0]       mask,
  input  fetchBundleT                 bundle,
  input  instrClassT [numParcels-1:0] parcelCls,
  output instrSlotT [numOut-1:0]      slots,
  output logic [numOut-1:0]           slotEn
);

  countT [numParcels-1:0] runCount;
  countT                  total;

  // Running count of set mask bits up to and including parcel k
  always_comb begin
    countT acc;
    acc = '0;
    for (int k = 0; k < numParcels; k++) begin
      acc         = acc + countT'(mask[k]);
      runCount[k] = acc;
    end
  end

  assign total = runCount[numParcels-1];

  always_comb begin
    slots  = '0;
    slotEn = '0;
    for (int i = 0; i < numOut; i++) begin
      slotEn[i] = total > countT'(i);
      for (int k = 0; k < numParcels; k++) begin
        if (mask[k] && (runCount[k] == countT'(i + 1))) begin  // Exactly one k matches
          slots[i].window = parcelWindow(bundle, k);
          slots[i].offset = offsetT'(k);
          slots[i].cont   = parcelCont(bundle.endBits, k);
          slots[i].cls    = parcelCls[k];
        end
      end
    end
  end

endmodule

// ==== bundlePredecoder.sv ====
module bundlePredecoder
  import isaPkg::*;
  import bundlePkg::*;
(
  input  logic                          clk,
  input  logic                          rstN,
  input  logic                          bundleValid,
  input  fetchBundleT                   bundle,
  output logic                          outValid,
  output instrSlotT [numSlots-1:0]      slots,
  output instrSlotT [numJumpSlots-1:0]  jumpSlots,
  output logic [numSlots-1:0]           slotEn,
  output logic [numJumpSlots-1:0]       jumpEn,
  output logic                          error,
  output logic                          jumpError
);

  instrClassT [numParcels-1:0]  parcelCls;
  logic                         stage1Valid;
  fetchBundleT                  stage1Bundle;
  instrClassT [numParcels-1:0]  stage1Cls;

  logic [numParcels-1:0]        startMask;
  logic [numParcels-1:0]        jumpMask;
  logic                         errorNext;
  logic                         jumpErrorNext;
  instrSlotT [numSlots-1:0]     slotsNext;
  instrSlotT [numJumpSlots-1:0] jumpSlotsNext;
  logic [numSlots-1:0]          slotEnNext;
  logic [numJumpSlots-1:0]      jumpEnNext;

  // Classify every parcel as if an instruction started there
  for (genvar k = 0; k < numParcels; k++) begin : genDecode
    logic [31:0] window;
    assign window = 32'(parcelWindow(bundle, k));  // Parcels k and k+1
    instrClassDecode decoder (
      .instr (window),
      .cont  (parcelCont(bundle.endBits, k)),
      .cls   (parcelCls[k])
    );
  end

  parcelBoundary boundary (
    .endBits   (stage1Bundle.endBits),
    .startOff  (stage1Bundle.startOff),
    .parcelCls (stage1Cls),
    .startMask (startMask),
    .jumpMask  (jumpMask),
    .error     (errorNext),
    .jumpError (jumpErrorNext)
  );

  slotCompactor #(.numOut(numSlots)) instrCompactor (
    .mask      (startMask),
    .bundle    (stage1Bundle),
    .parcelCls (stage1Cls),
    .slots     (slotsNext),
    .slotEn    (slotEnNext)
  );

  slotCompactor #(.numOut(numJumpSlots)) jumpCompactor (
    .mask      (jumpMask),
    .bundle    (stage1Bundle),
    .parcelCls (stage1Cls),
    .slots     (jumpSlotsNext),
    .slotEn    (jumpEnNext)
  );

  always_ff @(posedge clk) begin
    if (!rstN) begin
      stage1Valid <= 1'b0;
      outValid    <= 1'b0;
      slotEn      <= '0;
      jumpEn      <= '0;
      error       <= 1'b0;
      jumpError   <= 1'b0;
    end else begin
      stage1Valid <= bundleValid;
      outValid    <= stage1Valid;  // Single-cycle strobe out
      if (stage1Valid) begin
        slotEn    <= slotEnNext;
        jumpEn    <= jumpEnNext;
        error     <= errorNext;
        jumpError <= jumpErrorNext;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bundleValid) begin
      stage1Bundle <= bundle;
      stage1Cls    <= parcelCls;
    end
    if (stage1Valid) begin
      slots     <= slotsNext;
      jumpSlots <= jumpSlotsNext;
    end
  end

endmodule

// ==== tbClock.sv ====
module tbClock (
  output logic clk
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam time halfPeriod = 4ns;  // 8 ns period

  initial begin
    clk = 1'b0;
    forever #(halfPeriod) clk = ~clk;
  end

endmodule

// ==== bundlePredecoderTb.sv ====
module bundlePredecoderTb
  import isaPkg::*;
  import bundlePkg::*;
;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int resetCycles     = 8;
  localparam int numClassBundles = 4;
  localparam int numRandom       = 200;
  localparam int numJumpBundles  = 70;   // Ten per jump count 0..6
  localparam int numErrorBundles = 40;
  localparam int numPipe         = 60;
  localparam int numTests        = 6;
  localparam int drainCycles     = 6;
  localparam int stimCycles      = resetCycles + 2 + numPipe + numTests * drainCycles
                                 + 2 * (numClassBundles + numRandom + numJumpBundles
                                 + numErrorBundles);
  localparam int cycleLimit      = stimCycles + 50;

  typedef struct packed {
    instrSlotT [numSlots-1:0]     slots;
    instrSlotT [numJumpSlots-1:0] jumpSlots;
    logic [numSlots-1:0]          slotEn;
    logic [numJumpSlots-1:0]      jumpEn;
    logic                         error;
    logic                         jumpError;
  } resultT;

  logic                         clk;
  logic                         rstN;
  logic                         bundleValid;
  fetchBundleT                  bundle;
  logic                         outValid;
  instrSlotT [numSlots-1:0]     slots;
  instrSlotT [numJumpSlots-1:0] jumpSlots;
  logic [numSlots-1:0]          slotEn;
  logic [numJumpSlots-1:0]      jumpEn;
  logic                         error;
  logic                         jumpError;

  int     cycleCount;
  int     errorCount;
  int     bundlesChecked;
  int     testBundleMark;
  int     testErrorMark;
  int     testsRun;
  resultT expQ[$];
  string  nameQ[$];
  int     issueQ[$];

  // Directed opcodes for class decode, {subOp, opcode}
  logic [10:0] dirList [26] = '{
    {3'd0, 8'd0}, {3'd0, 8'd3}, {3'd0, 8'd4}, {3'd0, opAluLimit},
    {3'd0, opShiftLo}, {3'd0, opShiftHi}, {3'd0, opCmpLo}, {3'd0, opCmpHi},
    {3'd0, opLdStLo}, {3'd0, 8'd65}, {3'd0, opLdStHi}, {3'd0, opCondJumpLo},
    {3'd0, opCondJumpHi}, {3'd0, opLongJump}, {3'd0, opUncondJump},
    {subIndir, opBranchGroup}, {subCallA, opBranchGroup}, {subCallB, opBranchGroup},
    {subRet, opBranchGroup}, {3'd4, opBranchGroup}, {3'd5, opBranchGroup},
    {3'd6, opBranchGroup}, {3'd7, opBranchGroup}, {3'd0, opSys}, {3'd0, 8'd120},
    {3'd0, 8'd200}
  };

  tbClock clockGen (.clk(clk));

  bundlePredecoder dut (
    .clk         (clk),
    .rstN        (rstN),
    .bundleValid (bundleValid),
    .bundle      (bundle),
    .outValid    (outValid),
    .slots       (slots),
    .jumpSlots   (jumpSlots),
    .slotEn      (slotEn),
    .jumpEn      (jumpEn),
    .error       (error),
    .jumpError   (jumpError)
  );

  function automatic parcelT modelParcel(fetchBundleT b, int k);
    if (k < numParcels) return b.parcels[k];
    if (k == numParcels) return b.tailParcel;
    return '0;  // Past the tail
  endfunction

  function automatic logic modelEnd(fetchBundleT b, int k);
    if (k < 0) return 1'b1;
    if (k < numParcels) return b.endBits[k];
    return 1'b0;
  endfunction

  function automatic instrClassT modelClass(logic [7:0] op, logic [2:0] sub, logic longEnough);
    instrClassT c;
    c = '0;
    if (longEnough) begin
      if (op <= opAluLimit) begin
        if (op[2]) c.mul = 1'b1;
        else c.alu = 1'b1;
      end else if (op >= opShiftLo && op <= opShiftHi) begin
        c.shift = 1'b1;
      end else if (op >= opCmpLo && op <= opCmpHi) begin
        c.alu = 1'b1;
      end else if (op >= opLdStLo && op <= opLdStHi) begin
        if (op[0]) c.store = 1'b1;
        else c.load = 1'b1;
      end else if (op >= opCondJumpLo && op <= opCondJumpHi) begin
        c.jump = 1'b1;
        c.alu  = 1'b1;
      end else if (op == opLongJump || op == opUncondJump) begin
        c.jump = 1'b1;
      end else if (op == opBranchGroup) begin
        c.jump  = (sub == subIndir) || (sub == subRet) || (sub == subCallA) || (sub == subCallB);
        c.indir = (sub == subIndir) || (sub == subRet);
        c.store = (sub == subCallA) || (sub == subCallB);
      end
    end
    if (op == opSys) c.sys = 1'b1;
    return c;
  endfunction

  function automatic resultT modelPredict(fetchBundleT b);
    resultT     r;
    instrSlotT  s;
    parcelT     p;
    logic [3:0] c;
    int         nStart;
    int         nJump;
    r      = '0;
    nStart = 0;
    nJump  = 0;
    for (int k = 0; k < numParcels; k++) begin
      if (modelEnd(b, k - 1) && k >= int'(b.startOff)) begin
        p = modelParcel(b, k);
        for (int j = 0; j < 4; j++) c[j] = ~modelEnd(b, k + j);
        s.window = {modelParcel(b, k + 3), modelParcel(b, k + 2), modelParcel(b, k + 1), p};
        s.offset = offsetT'(k);
        s.cont   = c;
        s.cls    = modelClass(p[7:0], p[15:13], c[0]);
        if (nStart < numSlots) begin
          r.slots[nStart]  = s;
          r.slotEn[nStart] = 1'b1;
        end
        nStart++;
        if (s.cls.jump) begin
          if (nJump < numJumpSlots) begin
            r.jumpSlots[nJump] = s;
            r.jumpEn[nJump]    = 1'b1;
          end
          nJump++;
        end
      end
    end
    r.error     = (nStart > numSlots) || (b.startOff == 4'd15);
    r.jumpError = nJump > numJumpSlots;
    return r;
  endfunction

  function automatic logic [7:0] randOpcode();
    case ($urandom % 9)
      0: return 8'($urandom % (int'(opAluLimit) + 1));
      1: return 8'(opShiftLo + $urandom % (opShiftHi - opShiftLo + 1));
      2: return 8'(opCmpLo + $urandom % (opCmpHi - opCmpLo + 1));
      3: return 8'(opLdStLo + $urandom % (opLdStHi - opLdStLo + 1));
      4: return 8'(opCondJumpLo + $urandom % (opCondJumpHi - opCondJumpLo + 1));
      5: return ($urandom % 2) ? opLongJump : opUncondJump;
      6: return opBranchGroup;
      7: return opSys;
      default: return 8'($urandom);  // Mostly outside the map
    endcase
  endfunction

  function automatic parcelT randParcel();
    parcelT p;
    p      = 16'($urandom);
    p[7:0] = randOpcode();
    return p;
  endfunction

  function automatic fetchBundleT pairedBundle();
    fetchBundleT b;
    for (int k = 0; k < numParcels; k++) b.parcels[k] = randParcel();
    b.tailParcel = 16'($urandom);
    b.endBits    = 15'b010_1010_1010_1010;  // Two-parcel instructions at even parcels
    b.startOff   = '0;
    return b;
  endfunction

  function automatic fetchBundleT jumpBundle(int nJumps);
    fetchBundleT b;
    logic [7:0]  isJump;
    int          idx;
    b      = pairedBundle();
    isJump = '0;
    while ($countones(isJump) < nJumps) begin
      idx         = $urandom % 8;
      isJump[idx] = 1'b1;
    end
    for (int i = 0; i < 8; i++) begin
      if (isJump[i]) begin
        case ($urandom % 4)
          0: b.parcels[2*i][7:0] = opCondJumpLo;
          1: b.parcels[2*i][7:0] = opLongJump;
          2: b.parcels[2*i][7:0] = opUncondJump;
          default: b.parcels[2*i] = {3'($urandom % 4), 5'($urandom), opBranchGroup};
        endcase
      end else begin
        b.parcels[2*i][7:0] = ($urandom % 2) ? opLdStLo : 8'($urandom % 32);
      end
    end
    return b;
  endfunction

  task automatic sendBundle(fetchBundleT b, string name);
    @(posedge clk);
    #1;
    bundle      = b;
    bundleValid = 1'b1;
    expQ.push_back(modelPredict(b));
    nameQ.push_back(name);
    issueQ.push_back(cycleCount);
  endtask

  task automatic idleCycle();
    @(posedge clk);
    #1;
    bundleValid = 1'b0;
  endtask

  task automatic checkSlot(string name, instrSlotT exp, instrSlotT act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
      errorCount++;
    end
  endtask

  task automatic checkMask(string name, logic [numSlots-1:0] exp, logic [numSlots-1:0] act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
      errorCount++;
    end
  endtask

  task automatic checkFlag(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
      errorCount++;
    end
  endtask

  task automatic checkResult();
    resultT r;
    string  name;
    int     issued;
    if (expQ.size() == 0) begin
      $display("outValid went high in cycle %0d with no bundle in flight", cycleCount);
      errorCount++;
    end else begin
      r      = expQ.pop_front();
      name   = nameQ.pop_front();
      issued = issueQ.pop_front();
      if (cycleCount != issued + 2) begin
        $display("Result of %s came in cycle %0d, two cycles after input means cycle %0d",
                 name, cycleCount, issued + 2);
        errorCount++;
      end
      for (int i = 0; i < numSlots; i++) begin
        checkSlot($sformatf("%s slot%0d", name, i), r.slots[i], slots[i]);
      end
      for (int i = 0; i < numJumpSlots; i++) begin
        checkSlot($sformatf("%s jumpSlot%0d", name, i), r.jumpSlots[i], jumpSlots[i]);
      end
      checkMask({name, " slotEn"}, r.slotEn, slotEn);
      checkMask({name, " jumpEn"}, {4'b0, r.jumpEn}, {4'b0, jumpEn});
      checkFlag({name, " error"}, r.error, error);
      checkFlag({name, " jumpError"}, r.jumpError, jumpError);
      bundlesChecked++;
    end
  endtask

  task automatic endTest(string testName);
    while (expQ.size() > 0) @(posedge clk);
    repeat (2) @(posedge clk);
    $display("%-16s %0d bundles, %0d errors", testName,
             bundlesChecked - testBundleMark, errorCount - testErrorMark);
    testBundleMark = bundlesChecked;
    testErrorMark  = errorCount;
    testsRun++;
  endtask

  always @(posedge clk) cycleCount <= cycleCount + 1;

  always @(negedge clk) begin
    if (rstN && outValid) checkResult();  // Outputs settled mid-cycle
  end

  initial begin
    wait (cycleCount >= cycleLimit);
    $display("Timeout: run stopped after %0d cycles with %0d bundles in flight",
             cycleCount, expQ.size());
    $display("Simulation failed");
    $finish;
  end

  initial begin
    fetchBundleT b;
    int          n;
    void'($urandom(32'hb666bc22));
    cycleCount = 0;
    errorCount = 0;
    bundlesChecked = 0;
    testBundleMark = 0;
    testErrorMark = 0;
    testsRun = 0;
    rstN = 1'b0;
    bundleValid = 1'b0;
    bundle = '0;
    repeat (resetCycles) @(posedge clk);
    #1;
    rstN = 1'b1;

    @(negedge clk);
    checkFlag("reset outValid", 1'b0, outValid);
    checkMask("reset slotEn", '0, slotEn);
    checkMask("reset jumpEn", '0, {4'b0, jumpEn});
    checkFlag("reset error", 1'b0, error);
    checkFlag("reset jumpError", 1'b0, jumpError);
    endTest("reset");

    for (int t = 0; t < numClassBundles; t++) begin
      b = pairedBundle();
      for (int i = 0; i < 8; i++) begin
        n = (t * 8 + i) % 26;
        b.parcels[2*i][7:0]   = dirList[n][7:0];
        b.parcels[2*i][15:13] = dirList[n][10:8];
      end
      sendBundle(b, $sformatf("classDecode#%0d", t));
      idleCycle();
    end
    endTest("classDecode");

    for (int t = 0; t < numRandom; t++) begin
      for (int k = 0; k < numParcels; k++) b.parcels[k] = randParcel();
      b.tailParcel = 16'($urandom);
      b.endBits    = 15'($urandom);
      b.startOff   = 4'($urandom);
      sendBundle(b, $sformatf("instrCompaction#%0d", t));
      idleCycle();
    end
    endTest("instrCompaction");

    for (int t = 0; t < numJumpBundles; t++) begin
      sendBundle(jumpBundle(t % 7), $sformatf("jumpCompaction#%0d", t));
      idleCycle();
    end
    endTest("jumpCompaction");

    for (int t = 0; t < numErrorBundles; t++) begin
      for (int k = 0; k < numParcels; k++) b.parcels[k] = randParcel();
      b.tailParcel = 16'($urandom);
      b.endBits    = 15'($urandom | $urandom | $urandom);  // Dense starts
      b.startOff   = (t % 4 == 3) ? 4'd15 : 4'($urandom % 4);
      sendBundle(b, $sformatf("errorFlag#%0d", t));
      idleCycle();
    end
    endTest("errorFlag");

    for (int t = 0; t < numPipe; t++) begin
      for (int k = 0; k < numParcels; k++) b.parcels[k] = randParcel();
      b.tailParcel = 16'($urandom);
      b.endBits    = 15'($urandom);
      b.startOff   = 4'($urandom % 8);
      sendBundle(b, $sformatf("pipelining#%0d", t));
    end
    idleCycle();
    endTest("pipelining");

    $display("Totals: %0d tests, %0d bundles checked, %0d errors",
             testsRun, bundlesChecked, errorCount);
    if (errorCount == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== all.f ====
isaPkg.sv
bundlePkg.sv
instrClassDecode.sv
parcelBoundary.sv
slotCompactor.sv
bundlePredecoder.sv
tbClock.sv
bundlePredecoderTb.sv
